//--- Bender.yml
package:
  name: soc_top

sources:
  - verilog/bus_pkg.sv
  - verilog/soc_map_pkg.sv
  - verilog/obi_addr_decode.sv
  - verilog/data_ram.sv
  - verilog/soc_timer.sv
  - verilog/irq_ctrl.sv
  - verilog/obi_resp_mux.sv
  - verilog/soc_top.sv
  - target: test
    files:
      - tests/tb_soc_top.sv

//--- sim.f
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/obi_addr_decode.sv
verilog/data_ram.sv
verilog/soc_timer.sv
verilog/irq_ctrl.sv
verilog/obi_resp_mux.sv
verilog/soc_top.sv
tests/tb_soc_top.sv

//--- tests/tb_soc_top.sv
// testbench: clock, reset, watchdog, bus tasks, directed tests and compare tasks
`default_nettype none
`timescale 1ns/100ps

module tb_soc_top
    import bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_WORDS       = 16;
    localparam int ACCESS_CYCLES   = 3;    // idle, grant, response
    localparam int MAX_WAIT        = 8;
    localparam int TMR_VALUE_MAX   = 40;
    localparam int IRQ_ROUNDS      = 6;
    localparam int TEST_CYCLES     = 16 + 3 * NUM_WORDS * ACCESS_CYCLES + (NUM_WORDS + 2)
                                   + 6 * ACCESS_CYCLES
                                   + 2 * TMR_VALUE_MAX + 12 * ACCESS_CYCLES
                                   + IRQ_ROUNDS * 8 * ACCESS_CYCLES;
    localparam int WATCHDOG_MARGIN = 4;

    logic                   clk_i = 1'b0;
    logic                   arst_n_i;
    logic                   req_i;
    logic                   we_i;
    be_t                    be_i;
    addr_t                  addr_i;
    data_t                  wdata_i;
    logic                   gnt_o;
    logic                   rvalid_o;
    data_t                  rdata_o;
    logic                   err_o;
    logic [IRQ_SRC_NUM-2:0] irq_src_i;
    logic                   irq_o;
    logic [IRQ_ID_W-1:0]    irq_id_o;

    data_t ram_model [RAM_DEPTH];
    int    word_idx [NUM_WORDS];   // RAM words touched by the tests

    soc_top i_soc_top (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .be_i     (be_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .err_o    (err_o),
        .irq_src_i(irq_src_i),
        .irq_o    (irq_o),
        .irq_id_o (irq_id_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_data(input string test, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic compare_id(input string test, input logic [IRQ_ID_W-1:0] exp,
                              input logic [IRQ_ID_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic compare_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return merged;
    endfunction

    function automatic logic [IRQ_ID_W-1:0] lowest_active_id(input logic [IRQ_SRC_NUM-1:0] act);
        for (int i = 0; i < IRQ_SRC_NUM; i++) begin
            if (act[i]) return IRQ_ID_W'(i);
        end
        return '0;   // nothing active
    endfunction

    function automatic addr_t ram_addr(input int idx);
        return RAM_ADDR_BASE + (addr_t'(idx) << 2);
    endfunction

    // one request, then wait for the grant and the response
    task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                              input be_t be, output data_t rdata, output logic err);
        int wait_cycles;
        @(negedge clk_i);
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        be_i    = be;
        wait_cycles = 0;
        do begin
            @(posedge clk_i);
            wait_cycles++;
        end while (!gnt_o && wait_cycles < MAX_WAIT);
        if (!gnt_o) abort_run("Bus request was never granted");
        @(negedge clk_i);
        req_i = 1'b0;
        we_i  = 1'b0;
        wait_cycles = 0;
        while (!rvalid_o && wait_cycles < MAX_WAIT) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (!rvalid_o) abort_run("Granted request got no response");
        rdata = rdata_o;
        err   = err_o;
    endtask

    task automatic bus_write(input string test, input addr_t addr, input data_t wdata,
                             input be_t be);
        data_t rd;
        logic  err;
        bus_access(1'b1, addr, wdata, be, rd, err);
        compare_flag({test, " err"}, 1'b0, err);
        compare_data({test, " write rdata"}, '0, rd);
    endtask

    task automatic bus_read(input string test, input addr_t addr, output data_t rd);
        logic err;
        bus_access(1'b0, addr, '0, '1, rd, err);
        compare_flag({test, " err"}, 1'b0, err);
    endtask

    task automatic ram_test();
        data_t wdata;
        data_t rd;
        be_t   be;
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_idx[i] = i * 61 + int'($urandom_range(0, 60));   // distinct words
            wdata = $urandom;
            bus_write("ram full write", ram_addr(word_idx[i]), wdata, 4'hF);
            ram_model[word_idx[i]] = wdata;
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            wdata = $urandom;
            be    = be_t'($urandom_range(0, 15));
            bus_write("ram byte write", ram_addr(word_idx[i]), wdata, be);
            ram_model[word_idx[i]] = merge_bytes(ram_model[word_idx[i]], wdata, be);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            bus_read("ram readback", ram_addr(word_idx[i]), rd);
            compare_data("ram readback", ram_model[word_idx[i]], rd);
        end
    endtask

    // a new read every cycle, responses checked in request order
    task automatic back_to_back_test();
        for (int i = 0; i <= NUM_WORDS; i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                compare_flag("back-to-back rvalid", 1'b1, rvalid_o);
                compare_flag("back-to-back err", 1'b0, err_o);
                compare_data("back-to-back read", ram_model[word_idx[i-1]], rdata_o);
            end
            if (i < NUM_WORDS) begin
                req_i  = 1'b1;
                we_i   = 1'b0;
                be_i   = '1;
                addr_i = ram_addr(word_idx[i]);
                @(posedge clk_i);
                if (!gnt_o) abort_run("Back-to-back read was never granted");
            end else begin
                req_i = 1'b0;
            end
        end
        @(negedge clk_i);
        compare_flag("back-to-back extra rvalid", 1'b0, rvalid_o);
    endtask

    task automatic unmapped_test();
        data_t rd;
        logic  err;
        int    idx;
        idx = word_idx[0];
        bus_access(1'b0, 32'h1000_0000, '0, '1, rd, err);
        compare_flag("unmapped read err", 1'b1, err);
        compare_data("unmapped read data", '0, rd);
        // just past the RAM window, aliases the word if decode were partial
        bus_access(1'b1, ram_addr(idx) + 32'h1000, ~ram_model[idx], '1, rd, err);
        compare_flag("unmapped write err", 1'b1, err);
        compare_data("unmapped write data", '0, rd);
        bus_access(1'b1, 32'h4000_0000 | ram_addr(idx), ~ram_model[idx], '1, rd, err);
        compare_flag("unmapped write err", 1'b1, err);
        bus_read("ram after unmapped", ram_addr(idx), rd);
        compare_data("ram after unmapped", ram_model[idx], rd);
    endtask

    task automatic timer_test();
        data_t rd;
        data_t cmp_value;
        time   t0;
        int    cycles;
        cmp_value = data_t'($urandom_range(16, TMR_VALUE_MAX));
        bus_write("timer irq route", IRQ_ADDR_BASE | addr_t'(IRQ_ENABLE), 32'h1, 4'hF);
        bus_write("timer value", TIMER_ADDR_BASE | addr_t'(TMR_VALUE), cmp_value, 4'hF);
        bus_read("timer value", TIMER_ADDR_BASE | addr_t'(TMR_VALUE), rd);
        compare_data("timer value", cmp_value, rd);
        bus_write("timer enable", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), 32'h1, 4'hF);
        t0 = $time;
        do begin
            bus_read("timer poll", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), rd);
            cycles = int'(($time - t0) / CLK_PERIOD);
            if (!rd[2] && cycles > 2 * int'(cmp_value)) begin
                abort_run("Timer pending was not set within twice the compare value");
            end
        end while (!rd[2]);
        compare_data("timer ctrl pending", 32'h5, rd);
        compare_flag("timer irq masked", 1'b0, irq_o);
        bus_write("timer irq enable", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), 32'h3, 4'hF);
        @(negedge clk_i);   // source 0 latches one edge later
        compare_flag("timer irq", 1'b1, irq_o);
        compare_id("timer irq id", '0, irq_id_o);
        bus_write("timer stop", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), 32'h2, 4'hF);
        bus_write("timer clear", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), 32'h6, 4'hF);
        bus_read("timer pending clear", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), rd);
        compare_data("timer pending clear", 32'h2, rd);
        bus_write("timer irq clear", IRQ_ADDR_BASE | addr_t'(IRQ_PENDING), 32'h1, 4'hF);
        compare_flag("timer irq clear", 1'b0, irq_o);
        bus_write("timer off", TIMER_ADDR_BASE | addr_t'(TMR_CTRL), 32'h0, 4'hF);
        bus_write("timer irq unroute", IRQ_ADDR_BASE | addr_t'(IRQ_ENABLE), 32'h0, 4'hF);
    endtask

    task automatic irq_test();
        logic [IRQ_SRC_NUM-2:0] lines;
        logic [IRQ_SRC_NUM-1:0] enable;
        logic [IRQ_SRC_NUM-1:0] pending;
        logic [IRQ_ID_W-1:0]    exp_id;
        data_t                  rd;
        for (int r = 0; r < IRQ_ROUNDS; r++) begin
            lines  = (IRQ_SRC_NUM-1)'($urandom_range(1, 127));
            enable = IRQ_SRC_NUM'($urandom_range(0, 255));
            @(negedge clk_i);
            irq_src_i = lines;
            pending   = {lines, 1'b0};   // timer source stays quiet
            bus_write("irq enable", IRQ_ADDR_BASE | addr_t'(IRQ_ENABLE), data_t'(enable), '1);
            bus_read("irq pending", IRQ_ADDR_BASE | addr_t'(IRQ_PENDING), rd);
            compare_data("irq pending", data_t'(pending), rd);
            exp_id = lowest_active_id(pending & enable);
            compare_flag("irq request", |(pending & enable), irq_o);
            compare_id("irq id output", exp_id, irq_id_o);
            bus_read("irq id register", IRQ_ADDR_BASE | addr_t'(IRQ_ID), rd);
            compare_data("irq id register", data_t'(exp_id), rd);
            @(negedge clk_i);
            irq_src_i = '0;
            bus_write("irq clear", IRQ_ADDR_BASE | addr_t'(IRQ_PENDING), 32'hFF, '1);
            compare_flag("irq cleared", 1'b0, irq_o);
            bus_read("irq pending cleared", IRQ_ADDR_BASE | addr_t'(IRQ_PENDING), rd);
            compare_data("irq pending cleared", '0, rd);
        end
        bus_write("irq disable", IRQ_ADDR_BASE | addr_t'(IRQ_ENABLE), 32'h0, '1);
    endtask

    initial begin
        #(TEST_CYCLES * WATCHDOG_MARGIN * CLK_PERIOD);
        abort_run("Watchdog timeout, the tests did not finish in time");
    end

    initial begin
        void'($urandom(72203));
        arst_n_i  = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        be_i      = '0;
        addr_i    = '0;
        wdata_i   = '0;
        irq_src_i = '0;
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        compare_flag("reset rvalid", 1'b0, rvalid_o);
        compare_flag("reset err", 1'b0, err_o);
        compare_flag("reset irq", 1'b0, irq_o);

        ram_test();
        back_to_back_test();
        unmapped_test();
        timer_test();
        irq_test();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bus_pkg.sv
// bus widths and the address, data and byte-enable types
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;   // one enable per byte lane

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

endpackage

`default_nettype wire

//--- verilog/data_ram.sv
// word RAM slave with byte-enabled write and registered read
`default_nettype none
`timescale 1ns/100ps

module data_ram
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,
    input  wire logic   req_i,
    input  wire logic   we_i,
    input  wire be_t    be_i,
    input  wire addr_t  addr_i,
    input  wire data_t  wdata_i,
    output data_t       rdata_o
);

    data_t                mem [RAM_DEPTH];
    logic [RAM_IDX_W-1:0] word_idx;

    assign word_idx = addr_i[RAM_IDX_W+1:2];   // byte address to word

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (be_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // read word one cycle after the request, zero for writes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (req_i) begin
            rdata_o <= we_i ? '0 : mem[word_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/irq_ctrl.sv
// pending and enable registers with lowest-id priority select
`default_nettype none
`timescale 1ns/100ps

module irq_ctrl
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,
    input  wire logic                   req_i,
    input  wire logic                   we_i,
    input  wire addr_t                  addr_i,
    input  wire data_t                  wdata_i,
    input  wire logic [IRQ_SRC_NUM-1:0] src_i,
    output data_t                       rdata_o,
    output logic                        irq_o,
    output logic [IRQ_ID_W-1:0]         irq_id_o
);

    logic [IRQ_SRC_NUM-1:0] irq_enable;
    logic [IRQ_SRC_NUM-1:0] irq_pending;
    logic [IRQ_SRC_NUM-1:0] irq_active;
    logic [IRQ_SRC_NUM-1:0] pend_clr;
    irq_reg_off_e           reg_off;

    assign reg_off = irq_reg_off_e'(addr_i[REG_OFF_W-1:0]);

    assign pend_clr = (req_i && we_i && reg_off == IRQ_PENDING) ?
                      wdata_i[IRQ_SRC_NUM-1:0] : '0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_enable  <= '0;
            irq_pending <= '0;
        end else begin
            if (req_i && we_i && reg_off == IRQ_ENABLE) begin
                irq_enable <= wdata_i[IRQ_SRC_NUM-1:0];
            end
            irq_pending <= (irq_pending & ~pend_clr) | src_i;   // level sources re-set
        end
    end

    assign irq_active = irq_pending & irq_enable;
    assign irq_o      = |irq_active;

    // lowest index has priority
    always_comb begin
        irq_id_o = '0;
        for (int i = IRQ_SRC_NUM - 1; i >= 0; i--) begin
            if (irq_active[i]) begin
                irq_id_o = IRQ_ID_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (req_i) begin
            rdata_o <= '0;
            if (!we_i) begin
                case (reg_off)
                    IRQ_ENABLE:  rdata_o <= data_t'(irq_enable);
                    IRQ_PENDING: rdata_o <= data_t'(irq_pending);
                    IRQ_ID:      rdata_o <= data_t'(irq_id_o);
                    default:     rdata_o <= '0;
                endcase
            end
        end
    end

    a_id_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        irq_o |-> (irq_pending[irq_id_o] && irq_enable[irq_id_o])
    );

endmodule

`default_nettype wire

//--- verilog/obi_addr_decode.sv
// mask and base address decode, per-slave request and grant
`default_nettype none
`timescale 1ns/100ps

module obi_addr_decode
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,
    input  wire logic   req_i,
    input  wire addr_t  addr_i,
    output logic        ram_req_o,
    output logic        timer_req_o,
    output logic        irq_req_o,
    output slave_e      sel_o,
    output logic        gnt_o
);

    logic ram_hit;
    logic timer_hit;
    logic irq_hit;

    assign ram_hit   = (addr_i & RAM_ADDR_MASK)   == RAM_ADDR_BASE;
    assign timer_hit = (addr_i & TIMER_ADDR_MASK) == TIMER_ADDR_BASE;
    assign irq_hit   = (addr_i & IRQ_ADDR_MASK)   == IRQ_ADDR_BASE;

    always_comb begin
        if (ram_hit) begin
            sel_o = SLV_RAM;
        end else if (timer_hit) begin
            sel_o = SLV_TIMER;
        end else if (irq_hit) begin
            sel_o = SLV_IRQ;
        end else begin
            sel_o = SLV_NONE;   // error response later
        end
    end

    assign ram_req_o   = req_i && ram_hit;
    assign timer_req_o = req_i && timer_hit;
    assign irq_req_o   = req_i && irq_hit;

    // every slave takes the request at once
    assign gnt_o = req_i;

    // windows from the map must never overlap
    a_onehot_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({ram_req_o, timer_req_o, irq_req_o})
    );

endmodule

`default_nettype wire

//--- verilog/obi_resp_mux.sv
// response stage with rvalid, error flag and read data select
`default_nettype none
`timescale 1ns/100ps

module obi_resp_mux
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,
    input  wire logic   gnt_i,
    input  wire logic   we_i,
    input  wire slave_e sel_i,
    input  wire data_t  ram_rdata_i,
    input  wire data_t  timer_rdata_i,
    input  wire data_t  irq_rdata_i,
    output logic        rvalid_o,
    output logic        err_o,
    output data_t       rdata_o
);

    logic   gnt_q;
    logic   we_q;
    slave_e sel_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gnt_q <= 1'b0;
            we_q  <= 1'b0;
            sel_q <= SLV_RAM;
        end else begin
            gnt_q <= gnt_i;
            we_q  <= we_i;
            sel_q <= sel_i;
        end
    end

    assign rvalid_o = gnt_q;
    assign err_o    = gnt_q && (sel_q == SLV_NONE);

    always_comb begin
        rdata_o = '0;
        if (gnt_q && !we_q) begin
            case (sel_q)
                SLV_RAM:   rdata_o = ram_rdata_i;
                SLV_TIMER: rdata_o = timer_rdata_i;
                SLV_IRQ:   rdata_o = irq_rdata_i;
                default:   rdata_o = '0;   // unmapped
            endcase
        end
    end

    // response one cycle after each grant
    a_rvalid_after_gnt: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        gnt_i |=> rvalid_o
    );

endmodule

`default_nettype wire

//--- verilog/soc_map_pkg.sv
// memory map, slave index enum, interrupt sizes and register offset enums
`default_nettype none

package soc_map_pkg;

    import bus_pkg::*;

    // slave index, SLV_NONE marks an unmapped access
    typedef enum logic [1:0] {
        SLV_RAM   = 2'd0,
        SLV_TIMER = 2'd1,
        SLV_IRQ   = 2'd2,
        SLV_NONE  = 2'd3
    } slave_e;

    localparam addr_t RAM_ADDR_BASE   = 32'h0000_0000;
    localparam addr_t RAM_ADDR_MASK   = 32'hFFFF_F000;   // 4 KiB
    localparam addr_t TIMER_ADDR_BASE = 32'h2000_0000;
    localparam addr_t TIMER_ADDR_MASK = 32'hFFFF_F000;
    localparam addr_t IRQ_ADDR_BASE   = 32'h3000_0000;
    localparam addr_t IRQ_ADDR_MASK   = 32'hFFFF_F000;

    localparam int RAM_DEPTH   = 1024;              // words
    localparam int RAM_IDX_W   = $clog2(RAM_DEPTH);
    localparam int IRQ_SRC_NUM = 8;                 // src 0 is the timer
    localparam int IRQ_ID_W    = 3;
    localparam int REG_OFF_W   = 4;

    // timer register offsets
    typedef enum logic [REG_OFF_W-1:0] {
        TMR_CTRL  = 4'h0,   // en, irq en, pending (w1c)
        TMR_VALUE = 4'h4,
        TMR_COUNT = 4'h8    // read only
    } reg_off_e;

    // interrupt controller offsets, same window layout as the timer
    typedef enum logic [REG_OFF_W-1:0] {
        IRQ_ENABLE  = 4'h0,
        IRQ_PENDING = 4'h4, // w1c
        IRQ_ID      = 4'h8  // read only
    } irq_reg_off_e;

endpackage

`default_nettype wire

//--- verilog/soc_timer.sv
// compare timer slave with control, value and count registers and irq
`default_nettype none
`timescale 1ns/100ps

module soc_timer
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,
    input  wire logic   req_i,
    input  wire logic   we_i,
    input  wire be_t    be_i,
    input  wire addr_t  addr_i,
    input  wire data_t  wdata_i,
    output data_t       rdata_o,
    output logic        irq_o
);

    logic     tmr_en;
    logic     tmr_ie;
    logic     tmr_pend;
    data_t    tmr_value;
    data_t    tmr_count;
    reg_off_e reg_off;
    logic     ctrl_wr;
    logic     value_wr;
    logic     cmp_hit;

    assign reg_off  = reg_off_e'(addr_i[REG_OFF_W-1:0]);
    assign ctrl_wr  = req_i && we_i && (reg_off == TMR_CTRL) && be_i[0];
    assign value_wr = req_i && we_i && (reg_off == TMR_VALUE);
    assign cmp_hit  = tmr_en && (tmr_count == tmr_value);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tmr_en    <= 1'b0;
            tmr_ie    <= 1'b0;
            tmr_pend  <= 1'b0;
            tmr_value <= '0;
            tmr_count <= '0;
        end else begin
            if (ctrl_wr) begin
                tmr_en <= wdata_i[0];
                tmr_ie <= wdata_i[1];
            end

            // a new match wins over a clear in the same cycle
            if (cmp_hit) begin
                tmr_pend <= 1'b1;
            end else if (ctrl_wr && wdata_i[2]) begin
                tmr_pend <= 1'b0;
            end

            if (value_wr) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        tmr_value[b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end

            if (!tmr_en || value_wr || cmp_hit) begin
                tmr_count <= '0;   // restart on wrap or new compare value
            end else begin
                tmr_count <= tmr_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else if (req_i) begin
            rdata_o <= '0;
            if (!we_i) begin
                case (reg_off)
                    TMR_CTRL:  rdata_o <= {29'd0, tmr_pend, tmr_ie, tmr_en};
                    TMR_VALUE: rdata_o <= tmr_value;
                    TMR_COUNT: rdata_o <= tmr_count;
                    default:   rdata_o <= '0;
                endcase
            end
        end
    end

    assign irq_o = tmr_pend && tmr_ie;

    // holds across reprogramming of VALUE and of the enable
    a_count_le_value: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        tmr_en |-> (tmr_count <= tmr_value)
    );

endmodule

`default_nettype wire

//--- verilog/soc_top.sv
// bus decode, RAM, timer and interrupt controller slaves, response stage
`default_nettype none
`timescale 1ns/100ps

module soc_top
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    input  wire logic                   req_i,
    input  wire logic                   we_i,
    input  wire be_t                    be_i,
    input  wire addr_t                  addr_i,
    input  wire data_t                  wdata_i,
    output logic                        gnt_o,
    output logic                        rvalid_o,
    output data_t                       rdata_o,
    output logic                        err_o,

    input  wire logic [IRQ_SRC_NUM-2:0] irq_src_i,   // external lines 1 to 7
    output logic                        irq_o,
    output logic [IRQ_ID_W-1:0]         irq_id_o
);

    logic   ram_req;
    logic   timer_req;
    logic   irq_req;
    slave_e slave_sel;
    data_t  ram_rdata;
    data_t  timer_rdata;
    data_t  irq_rdata;
    logic   timer_irq;

    obi_addr_decode i_obi_addr_decode (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .addr_i     (addr_i),
        .ram_req_o  (ram_req),
        .timer_req_o(timer_req),
        .irq_req_o  (irq_req),
        .sel_o      (slave_sel),
        .gnt_o      (gnt_o)
    );

    data_ram i_data_ram (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .req_i   (ram_req),
        .we_i    (we_i),
        .be_i    (be_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (ram_rdata)
    );

    soc_timer i_soc_timer (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .req_i   (timer_req),
        .we_i    (we_i),
        .be_i    (be_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (timer_rdata),
        .irq_o   (timer_irq)
    );

    irq_ctrl i_irq_ctrl (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .req_i   (irq_req),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .src_i   ({irq_src_i, timer_irq}),   // timer is source 0
        .rdata_o (irq_rdata),
        .irq_o   (irq_o),
        .irq_id_o(irq_id_o)
    );

    obi_resp_mux i_obi_resp_mux (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .gnt_i        (gnt_o),
        .we_i         (we_i),
        .sel_i        (slave_sel),
        .ram_rdata_i  (ram_rdata),
        .timer_rdata_i(timer_rdata),
        .irq_rdata_i  (irq_rdata),
        .rvalid_o     (rvalid_o),
        .err_o        (err_o),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire
